// ==== hdl/bus_pkg.sv ====
/* Host bus types
   Single-word request, buffered entry and response as packed structs */
`default_nettype none

package bus_pkg;
  import soc_map_pkg::*;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } bus_op_e;

  typedef struct packed {
    bus_op_e                op;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wdata;
    logic [StrbWidth-1:0]   be;     // One bit per byte lane
  } bus_req_t;

  // Request tagged with its decoded target
  typedef struct packed {
    bus_req_t req;
    region_e  region;
  } bus_entry_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_resp_t;

endpackage

`default_nettype wire

// ==== hdl/bus_req_frontend.sv ====
/* Host request frontend
   Grants while the buffer has room, decodes the region and pushes the entry */
`default_nettype none

module bus_req_frontend
  import soc_map_pkg::*;
  import bus_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       ndmreset_n,
  input  wire logic       req_valid_i,
  input  wire bus_req_t   req_i,
  input  wire logic       full_i,
  output logic            gnt_o,
  output logic            push_o,
  output bus_entry_t      entry_o
);

  region_e region;

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    region = REGION_NONE;
    if ((req_i.addr >= RomBase) && (req_i.addr < RomBase + RomLength)) begin
      region = REGION_ROM;
    end else if ((req_i.addr >= ClintBase) && (req_i.addr < ClintBase + ClintLength)) begin
      region = REGION_CLINT;
    end else if ((req_i.addr >= GpioBase) && (req_i.addr < GpioBase + GpioLength)) begin
      region = REGION_GPIO;
    end
  end

  assign gnt_o  = ~full_i;                 // Room in the buffer
  assign push_o = req_valid_i & gnt_o;     // Accepted this cycle

  assign entry_o.req    = req_i;
  assign entry_o.region = region;

  // Host holds a stalled request until it is granted
  a_req_held: assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    (req_valid_i && !gnt_o) |=> (req_valid_i && $stable(req_i))
  ) else $error("host dropped or changed a request before it was granted");

endmodule

`default_nettype wire

// ==== hdl/clint_timer.sv ====
/* Core-local timer
   Divide-by-two rtc, 64-bit mtime and mtimecmp, registered timer interrupt */
`default_nettype none

module clint_timer
  import soc_map_pkg::*;
  import bus_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     ndmreset_n,
  input  wire logic                     access_i,
  input  wire bus_op_e                  op_i,
  input  wire logic [ClintWordBits-1:0] offset_i,
  input  wire logic [DataWidth-1:0]     wdata_i,
  input  wire logic [StrbWidth-1:0]     be_i,
  output logic [DataWidth-1:0]          rdata_o,
  output logic                          err_o,
  output logic                          timer_irq_o
);

  localparam logic [ClintWordBits-1:0] CmpLoIdx  = MtimecmpLoOff[ClintWordBits+1:2];
  localparam logic [ClintWordBits-1:0] CmpHiIdx  = MtimecmpHiOff[ClintWordBits+1:2];
  localparam logic [ClintWordBits-1:0] TimeLoIdx = MtimeLoOff[ClintWordBits+1:2];
  localparam logic [ClintWordBits-1:0] TimeHiIdx = MtimeHiOff[ClintWordBits+1:2];

  logic                   rtc_q;
  logic                   rtc_prev_q;
  logic [2*DataWidth-1:0] mtime_q;
  logic [2*DataWidth-1:0] mtimecmp_q;
  logic                   irq_q;
  logic                   cmp_we_lo;
  logic                   cmp_we_hi;

  // ------------------------------
  // rtc and mtime
  // ------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q      <= 1'b0;
      rtc_prev_q <= 1'b0;
      mtime_q    <= '0;
    end else begin
      rtc_q      <= ~rtc_q;            // Half the clk rate
      rtc_prev_q <= rtc_q;
      if (rtc_q && !rtc_prev_q) mtime_q <= mtime_q + 1'b1;   // rtc rising phase
    end
  end

  // Register decode, mtime is read-only from the bus
  always_comb begin
    rdata_o   = '0;
    err_o     = 1'b0;
    cmp_we_lo = 1'b0;
    cmp_we_hi = 1'b0;
    case (offset_i)
      CmpLoIdx: begin
        rdata_o   = mtimecmp_q[DataWidth-1:0];
        cmp_we_lo = access_i && (op_i == OP_WRITE);
      end
      CmpHiIdx: begin
        rdata_o   = mtimecmp_q[2*DataWidth-1:DataWidth];
        cmp_we_hi = access_i && (op_i == OP_WRITE);
      end
      TimeLoIdx: begin
        rdata_o = mtime_q[DataWidth-1:0];
        err_o   = (op_i == OP_WRITE);
      end
      TimeHiIdx: begin
        rdata_o = mtime_q[2*DataWidth-1:DataWidth];
        err_o   = (op_i == OP_WRITE);
      end
      default: err_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q <= '1;                  // No interrupt until programmed
    end else begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (cmp_we_lo && be_i[b]) mtimecmp_q[8*b +: 8] <= wdata_i[8*b +: 8];
        if (cmp_we_hi && be_i[b]) mtimecmp_q[DataWidth + 8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = irq_q;

  a_irq_follows_cmp: assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    (mtime_q >= mtimecmp_q) ##1 $stable(mtimecmp_q) |-> timer_irq_o
  ) else $error("timer interrupt missing after mtime reached mtimecmp");

endmodule

`default_nettype wire

// ==== hdl/periph_dispatch.sv ====
/* Target dispatch
   Serves the buffer head from ROM, GPIO or CLINT and registers the response */
`default_nettype none

module periph_dispatch
  import soc_map_pkg::*;
  import bus_pkg::*;
#(
  parameter int unsigned GpioWidth = 8
) (
  input  wire logic                 clk,
  input  wire logic                 ndmreset_n,
  input  wire bus_entry_t           head_i,
  input  wire logic                 empty_i,
  input  wire logic [GpioWidth-1:0] sw_i,
  output logic                      pop_o,
  output logic                      resp_valid_o,
  output bus_resp_t                 resp_o,
  output logic [GpioWidth-1:0]      leds_o,
  output logic                      timer_irq_o
);

  `include "rom_image.svh"

  localparam int unsigned RomIdxBits = $clog2(RomWords);

  typedef enum logic {
    IDLE,
    RESP
  } state_e;

  state_e                    state_q;
  bus_resp_t                 resp_q;
  logic [GpioWidth-1:0]      leds_q;

  logic [AddrWidth-1:0]      rom_off;
  logic [AddrWidth-1:0]      clint_off;
  logic [AddrWidth-1:0]      gpio_off;
  logic [DataWidth-1:0]      rdata;
  logic                      err;
  logic                      led_we;
  logic                      clint_access;
  logic [DataWidth-1:0]      clint_rdata;
  logic                      clint_err;

  assign rom_off   = head_i.req.addr - RomBase;
  assign clint_off = head_i.req.addr - ClintBase;
  assign gpio_off  = head_i.req.addr - GpioBase;

  assign pop_o        = (state_q == IDLE) && !empty_i;
  assign clint_access = pop_o && (head_i.region == REGION_CLINT);

  // ------------------------------
  // Serve the head entry
  // ------------------------------
  always_comb begin
    rdata  = '0;
    err    = 1'b0;
    led_we = 1'b0;
    case (head_i.region)
      REGION_ROM: begin
        if (head_i.req.op == OP_WRITE) err = 1'b1;   // ROM is read-only
        else rdata = RomImage[rom_off[RomIdxBits+1:2]];
      end
      REGION_GPIO: begin
        if (gpio_off[AddrWidth-1:2] == LedOff[AddrWidth-1:2]) begin
          if (head_i.req.op == OP_WRITE) led_we = pop_o;
          else rdata = DataWidth'(leds_q);
        end else if (gpio_off[AddrWidth-1:2] == SwOff[AddrWidth-1:2]) begin
          if (head_i.req.op == OP_WRITE) err = 1'b1;  // Switch word cannot be written
          else rdata = DataWidth'(sw_i);
        end else begin
          err = 1'b1;
        end
      end
      REGION_CLINT: begin
        rdata = clint_rdata;
        err   = clint_err;
      end
      default: err = 1'b1;
    endcase
    // Only successful reads carry data
    if (err || head_i.req.op == OP_WRITE) rdata = '0;
  end

  // LED register, byte lanes gate each bit
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      leds_q <= '0;
    end else if (led_we) begin
      for (int i = 0; i < GpioWidth; i++) begin
        if (head_i.req.be[i / 8]) leds_q[i] <= head_i.req.wdata[i];
      end
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (pop_o) state_q <= RESP;
        default: state_q <= IDLE;             // Response pulse lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      resp_q.rdata <= rdata;
      resp_q.err   <= err;
    end
  end

  assign resp_valid_o = (state_q == RESP);
  assign resp_o       = resp_q;
  assign leds_o       = leds_q;

  clint_timer clint_inst (
    .clk         ( clk                            ),
    .ndmreset_n  ( ndmreset_n                     ),
    .access_i    ( clint_access                   ),
    .op_i        ( head_i.req.op                  ),
    .offset_i    ( clint_off[ClintWordBits+1:2]   ),
    .wdata_i     ( head_i.req.wdata               ),
    .be_i        ( head_i.req.be                  ),
    .rdata_o     ( clint_rdata                    ),
    .err_o       ( clint_err                      ),
    .timer_irq_o ( timer_irq_o                    )
  );

  a_resp_single: assert property (
    @(posedge clk) disable iff (!ndmreset_n) resp_valid_o |=> !resp_valid_o
  ) else $error("response valid held for two cycles");

endmodule

`default_nettype wire

// ==== hdl/req_fifo.sv ====
/* In-order request buffer
   Circular storage with read/write pointers and an occupancy count */
`default_nettype none

module req_fifo
  import bus_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  wire logic       clk,
  input  wire logic       ndmreset_n,
  input  wire logic       push_i,
  input  wire bus_entry_t entry_i,
  input  wire logic       pop_i,
  output bus_entry_t      head_o,
  output logic            full_o,
  output logic            empty_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  bus_entry_t            mem_q [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   count_q;

  assign full_o  = (count_q == CntWidth'(FifoDepth));
  assign empty_o = (count_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;      // Both or neither
      endcase
    end
  end

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!ndmreset_n) pop_i |-> !empty_o
  ) else $error("pop from an empty request buffer");

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!ndmreset_n) push_i |-> !full_o
  ) else $error("push into a full request buffer");

endmodule

`default_nettype wire

// ==== hdl/soc_bus_top.sv ====
/* Peripheral subsystem top
   Host port into frontend, request buffer and target dispatch */
`default_nettype none

module soc_bus_top
  import bus_pkg::*;
#(
  parameter int unsigned FifoDepth = 4,
  parameter int unsigned GpioWidth = 8
) (
  input  wire logic                 clk,
  input  wire logic                 ndmreset_n,
  input  wire logic                 req_valid_i,
  input  wire bus_req_t             req_i,
  input  wire logic [GpioWidth-1:0] sw_i,
  output logic                      gnt_o,
  output logic                      resp_valid_o,
  output bus_resp_t                 resp_o,
  output logic [GpioWidth-1:0]      leds_o,
  output logic                      timer_irq_o
);

  logic       push;
  logic       pop;
  logic       full;
  logic       empty;
  bus_entry_t push_entry;
  bus_entry_t head_entry;

  bus_req_frontend frontend_inst (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .full_i      ( full        ),
    .gnt_o       ( gnt_o       ),
    .push_o      ( push        ),
    .entry_o     ( push_entry  )
  );

  req_fifo #(
    .FifoDepth ( FifoDepth )
  ) fifo_inst (
    .clk        ( clk        ),
    .ndmreset_n ( ndmreset_n ),
    .push_i     ( push       ),
    .entry_i    ( push_entry ),
    .pop_i      ( pop        ),
    .head_o     ( head_entry ),
    .full_o     ( full       ),
    .empty_o    ( empty      )
  );

  periph_dispatch #(
    .GpioWidth ( GpioWidth )
  ) dispatch_inst (
    .clk          ( clk          ),
    .ndmreset_n   ( ndmreset_n   ),
    .head_i       ( head_entry   ),
    .empty_i      ( empty        ),
    .sw_i         ( sw_i         ),
    .pop_o        ( pop          ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .leds_o       ( leds_o       ),
    .timer_irq_o  ( timer_irq_o  )
  );

endmodule

`default_nettype wire

// ==== hdl/soc_map_pkg.sv ====
/* Peripheral subsystem address map
   Region tags plus base, length and register offsets of every target */
`default_nettype none

package soc_map_pkg;

  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_CLINT,
    REGION_GPIO,
    REGION_NONE   // Unmapped, answered with an error
  } region_e;

  // ------------------------------
  // Regions
  // ------------------------------
  localparam logic [31:0] RomBase     = 32'h0000_1000;
  localparam logic [31:0] RomLength   = 32'h0000_0100;  // 64 words
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0001_0000;
  localparam logic [31:0] GpioBase    = 32'h4000_0000;
  localparam logic [31:0] GpioLength  = 32'h0000_1000;

  // Word offset bits inside the CLINT window
  localparam int unsigned ClintWordBits = 14;

  // ------------------------------
  // Register offsets
  // ------------------------------
  localparam logic [31:0] MtimecmpLoOff = 32'h0000_4000;
  localparam logic [31:0] MtimecmpHiOff = 32'h0000_4004;
  localparam logic [31:0] MtimeLoOff    = 32'h0000_BFF8;
  localparam logic [31:0] MtimeHiOff    = 32'h0000_BFFC;
  localparam logic [31:0] LedOff        = 32'h0000_0000;
  localparam logic [31:0] SwOff         = 32'h0000_0008;

endpackage

`default_nettype wire

// ==== include/rom_image.svh ====
/* Boot ROM image holding one 32-bit word per entry */

localparam int unsigned RomWords = 64;

// Short boot stub followed by fill patterns
localparam logic [31:0] RomImage [RomWords] = '{
  32'h0000_0297, 32'h0202_8593, 32'hF140_2573, 32'h0182_B283,
  32'h0002_8067, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000,
  32'h1050_0073, 32'hFFDF_F06F, 32'h0010_0513, 32'h00B5_0533,
  32'h4000_0637, 32'h00A6_2023, 32'hFF5F_F06F, 32'h0000_0013,
  32'hDEAD_BEEF, 32'hCAFE_F00D, 32'h1234_5678, 32'h8765_4321,
  32'h0F0F_0F0F, 32'hF0F0_F0F0, 32'h5555_AAAA, 32'hAAAA_5555,
  32'h0000_0001, 32'h0000_0002, 32'h0000_0004, 32'h0000_0008,
  32'h0000_0010, 32'h0000_0020, 32'h0000_0040, 32'h0000_0080,
  32'h0101_0101, 32'h0202_0202, 32'h0404_0404, 32'h0808_0808,
  32'h1010_1010, 32'h2020_2020, 32'h4040_4040, 32'h8080_8080,
  32'h3C3C_C3C3, 32'h9669_6996, 32'h7E81_817E, 32'hA5A5_5A5A,
  32'h0123_4567, 32'h89AB_CDEF, 32'hFEDC_BA98, 32'h7654_3210,
  32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'h4444_4444,
  32'h6666_6666, 32'h7777_7777, 32'h9999_9999, 32'hBBBB_BBBB,
  32'hC001_D00D, 32'hB16B_00B5, 32'h0BAD_F00D, 32'hFACE_FEED,
  32'h00FF_00FF, 32'hFF00_FF00, 32'h7FFF_FFFF, 32'hFFFF_FFFE
};

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_soc_bus \
  --Mdir "$BUILD_DIR" -o sim_tb

"./$BUILD_DIR/sim_tb" | tee "$LOG"

if grep -qx "TEST OK" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

// ==== tb.f ====
+incdir+include
hdl/soc_map_pkg.sv
hdl/bus_pkg.sv
hdl/bus_req_frontend.sv
hdl/req_fifo.sv
hdl/clint_timer.sv
hdl/periph_dispatch.sv
hdl/soc_bus_top.sv
verif/tb_soc_bus.sv

// ==== verif/tb_soc_bus.sv ====
/* Peripheral subsystem testbench
   LFSR driven host accesses checked against a model of ROM, GPIO and CLINT */
`default_nettype none

module tb_soc_bus
  import soc_map_pkg::*;
  import bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  `include "rom_image.svh"

  localparam int NumRequests = 400;
  localparam int NumDirected = 9;
  localparam int CycleLimit  = NumRequests * 10;  // About 3 cycles per request, rest is margin
  localparam logic [1:0] NoFlag  = 2'b00;
  localparam logic [1:0] IrqRise = 2'b01;
  localparam logic [1:0] IrqFall = 2'b10;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic [7:0]  leds;      // LED state once this access is served
    logic        mtime_lo;  // Data checked against the mtime bounds
    logic        irq_rise;
    logic        irq_fall;
  } exp_t;

  logic        clk;
  logic        ndmreset_n;
  logic        req_valid_i;
  bus_req_t    req_i;
  logic [7:0]  sw_i;
  logic        gnt_o;
  logic        resp_valid_o;
  bus_resp_t   resp_o;
  logic [7:0]  leds_o;
  logic        timer_irq_o;

  logic [15:0] lfsr = 16'd71;
  int          cycle_cnt = 0;
  int          grants = 0;
  int          responses = 0;
  int          data_errs = 0;
  int          proto_errs = 0;
  int          irq_wait = 0;
  logic        irq_low_next = 1'b0;
  logic        saw_gnt_low = 1'b0;
  logic [31:0] last_mtime = '0;
  int          last_mtime_cyc = 0;
  logic [7:0]  led_m = '0;
  logic [63:0] cmp_m = '1;
  exp_t        exp_q [$];

  soc_bus_top soc_bus_top_inst (
    .clk          ( clk          ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .sw_i         ( sw_i         ),
    .gnt_o        ( gnt_o        ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .leds_o       ( leds_o       ),
    .timer_irq_o  ( timer_irq_o  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= CycleLimit);
    $display("Run timed out after %0d cycles with %0d responses missing", cycle_cnt, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic bus_req_t mk_req(input bus_op_e op, input logic [31:0] addr,
                                      input logic [31:0] data);
    bus_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = data;
    r.be    = 4'hF;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      data_errs++;
      $display("CHECK FAILED at %0t: %s expected 0x%h got 0x%h", $time, name, exp, got);
    end
  endtask

  // ------------------------------
  // Reference model, run at grant
  // ------------------------------
  task automatic model_access(input bus_req_t r, input logic [1:0] flags);
    exp_t        e;
    logic [31:0] off;
    e = '0;
    e.irq_rise = flags[0];
    e.irq_fall = flags[1];
    if (r.addr >= RomBase && r.addr < RomBase + RomLength) begin
      off = r.addr - RomBase;
      if (r.op == OP_WRITE) e.err = 1'b1;
      else e.rdata = RomImage[off[7:2]];
    end else if (r.addr >= GpioBase && r.addr < GpioBase + GpioLength) begin
      off = (r.addr - GpioBase) & 32'hFFFF_FFFC;
      if (off == LedOff) begin
        if (r.op == OP_READ) e.rdata = {24'h0, led_m};
        else if (r.be[0]) led_m = r.wdata[7:0];  // Only lane 0 reaches the LEDs
      end else if (off == SwOff && r.op == OP_READ) begin
        e.rdata = {24'h0, sw_i};
      end else begin
        e.err = 1'b1;
      end
    end else if (r.addr >= ClintBase && r.addr < ClintBase + ClintLength) begin
      off = (r.addr - ClintBase) & 32'hFFFF_FFFC;
      if (off == MtimecmpLoOff || off == MtimecmpHiOff) begin
        for (int b = 0; b < 4; b++) begin
          if (r.op == OP_WRITE && r.be[b]) begin
            if (off == MtimecmpLoOff) cmp_m[8*b +: 8] = r.wdata[8*b +: 8];
            else cmp_m[32 + 8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
        if (r.op == OP_READ) e.rdata = (off == MtimecmpLoOff) ? cmp_m[31:0] : cmp_m[63:32];
      end else if (off == MtimeLoOff || off == MtimeHiOff) begin
        e.err      = (r.op == OP_WRITE);               // mtime is read-only
        e.mtime_lo = (r.op == OP_READ) && (off == MtimeLoOff);
      end else begin
        e.err = 1'b1;
      end
    end else begin
      e.err = 1'b1;
    end
    e.leds = led_m;
    exp_q.push_back(e);
  endtask

  task automatic check_resp();
    exp_t e;
    responses++;
    assert (exp_q.size() != 0) else begin
      proto_errs++;
      $display("Response at %0t arrived with no request outstanding", $time);
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check_value("resp_o.err", 32'(e.err), 32'(resp_o.err));
      check_value("leds_o", 32'(e.leds), 32'(leds_o));
      if (e.mtime_lo) begin
        assert (resp_o.rdata >= last_mtime &&
                resp_o.rdata - last_mtime <= (cycle_cnt - last_mtime_cyc) / 2 + 1) else begin
          data_errs++;
          $display("CHECK FAILED at %0t: resp_o.rdata (mtime low) previous 0x%h got 0x%h",
                   $time, last_mtime, resp_o.rdata);
        end
        last_mtime     = resp_o.rdata;
        last_mtime_cyc = cycle_cnt;
      end else begin
        check_value("resp_o.rdata", e.rdata, resp_o.rdata);
      end
      if (irq_low_next) check_value("timer_irq_o", 32'd0, 32'(timer_irq_o));
      irq_low_next = e.irq_fall;
      if (e.irq_rise) irq_wait = 4;
    end
  endtask

  // One cycle, monitor first, inputs change after it
  task automatic tick();
    @(negedge clk);
    if (!gnt_o) saw_gnt_low = 1'b1;
    if (irq_wait > 0) begin
      if (timer_irq_o) irq_wait = 0;
      else begin
        irq_wait--;
        assert (irq_wait > 0) else begin
          proto_errs++;
          $display("Timer interrupt did not rise within 4 cycles, at %0t", $time);
        end
      end
    end
    if (resp_valid_o) check_resp();
  endtask

  task automatic send_req(input bus_req_t r, input logic [1:0] flags);
    req_valid_i = 1'b1;
    req_i       = r;
    while (!gnt_o) tick();   // Hold until granted
    model_access(r, flags);
    grants++;
    tick();
  endtask

  task automatic drain();
    while (exp_q.size() != 0) tick();
  endtask

  task automatic random_req(output bus_req_t r);
    logic [31:0] sel;
    logic [31:0] pick;
    logic [31:0] v;
    rand_bits(3, sel);
    rand_bits(2, pick);
    rand_bits(1, v);
    r.op = v[0] ? OP_WRITE : OP_READ;
    rand_bits(32, v);
    r.wdata = v;
    rand_bits(4, v);
    r.be = v[3:0];
    rand_bits(14, v);   // Word index for free offsets
    case (sel[2:0])
      3'd0, 3'd1: r.addr = RomBase + 32'({v[5:0], 2'b00});
      3'd2, 3'd3: begin
        case (pick[1:0])
          2'd0, 2'd2: r.addr = GpioBase + LedOff;
          2'd1:       r.addr = GpioBase + SwOff;
          default:    r.addr = GpioBase + 32'({v[9:0], 2'b00});
        endcase
      end
      3'd4, 3'd5: begin
        case (pick[1:0])
          2'd0:    r.addr = ClintBase + MtimecmpLoOff;
          2'd1:    r.addr = ClintBase + MtimecmpHiOff;
          2'd2:    r.addr = ClintBase + MtimeLoOff;
          default: r.addr = ClintBase + 32'({v[13:0], 2'b00});
        endcase
      end
      3'd6:    r.addr = 32'({v[9:0], 2'b00});                   // Below the ROM
      default: r.addr = GpioBase + GpioLength + 32'({v[9:0], 2'b00});
    endcase
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    bus_req_t    r;
    logic [31:0] v;
    int          sent;
    ndmreset_n  = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    sw_i        = '0;
    sent        = 0;
    repeat (4) @(negedge clk);
    ndmreset_n     = 1'b1;
    last_mtime_cyc = cycle_cnt;
    check_value("gnt_o", 32'd1, 32'(gnt_o));
    check_value("resp_valid_o", 32'd0, 32'(resp_valid_o));
    check_value("leds_o", 32'd0, 32'(leds_o));
    check_value("timer_irq_o", 32'd0, 32'(timer_irq_o));

    // Interrupt raise and clear around a fresh mtime sample
    send_req(mk_req(OP_READ, ClintBase + MtimecmpLoOff, '0), NoFlag);
    send_req(mk_req(OP_READ, ClintBase + MtimecmpHiOff, '0), NoFlag);
    req_valid_i = 1'b0;
    repeat (20) tick();
    send_req(mk_req(OP_READ, ClintBase + MtimeLoOff, '0), NoFlag);
    req_valid_i = 1'b0;
    drain();
    send_req(mk_req(OP_WRITE, ClintBase + MtimecmpLoOff, last_mtime), NoFlag);
    send_req(mk_req(OP_WRITE, ClintBase + MtimecmpHiOff, '0), IrqRise);
    req_valid_i = 1'b0;
    drain();
    repeat (6) tick();
    send_req(mk_req(OP_WRITE, ClintBase + MtimecmpHiOff, '1), NoFlag);
    send_req(mk_req(OP_WRITE, ClintBase + MtimecmpLoOff, '1), IrqFall);
    send_req(mk_req(OP_READ, ClintBase + MtimecmpLoOff, '0), NoFlag);
    send_req(mk_req(OP_READ, ClintBase + MtimecmpHiOff, '0), NoFlag);
    req_valid_i = 1'b0;
    drain();

    // Random bursts, switches only move while nothing is pending
    while (sent < NumRequests - NumDirected) begin
      drain();
      rand_bits(8, v);
      sw_i = v[7:0];
      rand_bits(4, v);
      for (int i = 0; i <= int'(v[3:0]) && sent < NumRequests - NumDirected; i++) begin
        random_req(r);
        send_req(r, NoFlag);
        sent++;
      end
      req_valid_i = 1'b0;
      rand_bits(2, v);
      repeat (v[1:0]) tick();
    end
    drain();
    repeat (4) tick();   // Catch stray responses

    assert (grants == responses) else begin
      proto_errs++;
      $display("Granted %0d requests but saw %0d responses", grants, responses);
    end
    assert (saw_gnt_low) else begin
      proto_errs++;
      $display("gnt_o never dropped during the bursts");
    end
    $display("Error counts: data %0d, protocol %0d", data_errs, proto_errs);
    if (data_errs + proto_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
